/* verilog/uplink_capture_pkg.sv */
`default_nettype none

package uplink_capture_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // bus and frame widths
    ////////////////////////////////////////////////////////////////////////////
    localparam int AXI_DATA_W = 32;    // axi4-lite data bus
    localparam int AXI_ADDR_W = 11;    // byte address
    localparam int REG_N      = 11;    // mapped registers, 0..10
    localparam int FRAME_W    = 234;   // lpgbt uplink user data

    typedef logic [FRAME_W-1:0] frame_t;

    // register map, word indices
    typedef enum logic [3:0] {
        REG_CTRL    = 4'd0,    // bit 0 capture enable
        REG_STATUS  = 4'd1,    // bit 0 empty, bit 1 full
        REG_FRAME0  = 4'd2,    // head frame [31:0]
        REG_FRAME1  = 4'd3,
        REG_FRAME2  = 4'd4,
        REG_FRAME3  = 4'd5,
        REG_FRAME4  = 4'd6,
        REG_FRAME5  = 4'd7,
        REG_FRAME6  = 4'd8,
        REG_FRAME7  = 4'd9,    // top slice, zero-extended, read pops
        REG_FEC_CNT = 4'd10    // saturating fec error count
    } reg_idx_e;

    // one register write, valid for the accept cycle only
    typedef struct packed {
        logic                    valid;
        reg_idx_e                idx;
        logic [AXI_DATA_W-1:0]   data;
        logic [AXI_DATA_W/8-1:0] strb;
    } reg_wr_t;

    // one register read request
    typedef struct packed {
        logic     valid;
        reg_idx_e idx;
    } reg_rd_t;

    typedef struct packed {
        logic full;     // bit 1
        logic empty;    // bit 0
    } status_t;

endpackage

`default_nettype wire

/* verilog/cdc_async_fifo.sv */
`default_nettype none

module cdc_async_fifo #(
    parameter int WIDTH      = 32,
    parameter int DEPTH_LOG2 = 4      // 2 or more
) (
    // write side
    input  wire logic             wr_clk_i,
    input  wire logic             wr_rst_n_i,
    input  wire logic             wr_en_i,
    input  wire logic [WIDTH-1:0] din_i,
    output logic                  full_o,

    // read side, first word fall through
    input  wire logic             rd_clk_i,
    input  wire logic             rd_rst_n_i,
    input  wire logic             rd_en_i,
    output logic [WIDTH-1:0]      dout_o,
    output logic                  empty_o
);

    localparam int DEPTH = 1 << DEPTH_LOG2;
    localparam int PW    = DEPTH_LOG2 + 1;    // extra wrap bit

    logic [WIDTH-1:0] mem [DEPTH];

    logic [1:0]    wr_rst_q, rd_rst_q;        // reset synchronizers
    logic [PW-1:0] wr_bin, wr_gray, wr_bin_nxt;
    logic [PW-1:0] rd_bin, rd_gray, rd_bin_nxt;
    logic [PW-1:0] rq1_gray, rq2_gray;        // read ptr in write domain
    logic [PW-1:0] wq1_gray, wq2_gray;        // write ptr in read domain
    logic          push, pop;

    function automatic logic [PW-1:0] bin2gray(input logic [PW-1:0] b);
        return b ^ (b >> 1);
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // write domain
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge wr_clk_i) begin
        wr_rst_q <= {wr_rst_q[0], wr_rst_n_i};
    end

    assign push       = wr_en_i && !full_o;    // drop when full
    assign wr_bin_nxt = wr_bin + {{DEPTH_LOG2{1'b0}}, push};

    always_ff @(posedge wr_clk_i) begin
        if (!wr_rst_q[1]) begin
            wr_bin   <= '0;
            wr_gray  <= '0;
            rq1_gray <= '0;
            rq2_gray <= '0;
        end else begin
            wr_bin   <= wr_bin_nxt;
            wr_gray  <= bin2gray(wr_bin_nxt);
            rq1_gray <= rd_gray;
            rq2_gray <= rq1_gray;
        end
    end

    always_ff @(posedge wr_clk_i) begin
        if (push) begin
            mem[wr_bin[DEPTH_LOG2-1:0]] <= din_i;
        end
    end

    // full: top two gray bits inverted, rest equal; lags by the sync
    assign full_o = (wr_gray == {~rq2_gray[PW-1:PW-2], rq2_gray[PW-3:0]});

    ////////////////////////////////////////////////////////////////////////////
    // read domain
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge rd_clk_i) begin
        rd_rst_q <= {rd_rst_q[0], rd_rst_n_i};
    end

    assign pop        = rd_en_i && !empty_o;
    assign rd_bin_nxt = rd_bin + {{DEPTH_LOG2{1'b0}}, pop};

    always_ff @(posedge rd_clk_i) begin
        if (!rd_rst_q[1]) begin
            rd_bin   <= '0;
            rd_gray  <= '0;
            wq1_gray <= '0;
            wq2_gray <= '0;
        end else begin
            rd_bin   <= rd_bin_nxt;
            rd_gray  <= bin2gray(rd_bin_nxt);
            wq1_gray <= wr_gray;
            wq2_gray <= wq1_gray;
        end
    end

    assign empty_o = (rd_gray == wq2_gray);
    assign dout_o  = mem[rd_bin[DEPTH_LOG2-1:0]];    // head, no read latency

endmodule

`default_nettype wire

/* verilog/axi4lite_reg_slave.sv */
`default_nettype none

module axi4lite_reg_slave
    import uplink_capture_pkg::*;
(
    input  wire logic                    S_AXI_ACLK,
    input  wire logic                    S_AXI_ARESETN,

    // write address / data channels
    input  wire logic [AXI_ADDR_W-1:0]   s_axi_awaddr_i,
    input  wire logic [2:0]              s_axi_awprot_i,    // not decoded
    input  wire logic                    s_axi_awvalid_i,
    output logic                         s_axi_awready_o,
    input  wire logic [AXI_DATA_W-1:0]   s_axi_wdata_i,
    input  wire logic [AXI_DATA_W/8-1:0] s_axi_wstrb_i,
    input  wire logic                    s_axi_wvalid_i,
    output logic                         s_axi_wready_o,

    // write response
    output logic [1:0]                   s_axi_bresp_o,
    output logic                         s_axi_bvalid_o,
    input  wire logic                    s_axi_bready_i,

    // read address / data channels
    input  wire logic [AXI_ADDR_W-1:0]   s_axi_araddr_i,
    input  wire logic [2:0]              s_axi_arprot_i,    // not decoded
    input  wire logic                    s_axi_arvalid_i,
    output logic                         s_axi_arready_o,
    output logic [AXI_DATA_W-1:0]        s_axi_rdata_o,
    output logic [1:0]                   s_axi_rresp_o,
    output logic                         s_axi_rvalid_o,
    input  wire logic                    s_axi_rready_i,

    // register map side
    output reg_wr_t                      reg_wr_o,
    output reg_rd_t                      reg_rd_o,
    input  wire logic [AXI_DATA_W-1:0]   rd_data_i          // comb from map
);

    localparam logic [1:0] RESP_OKAY = 2'b00;

    logic wr_accept;
    logic rd_accept;
    logic bvalid_q;
    logic rvalid_q;
    logic [AXI_DATA_W-1:0] rdata_q;

    // byte address -> word index, anything past the map goes to 15
    function automatic reg_idx_e addr_to_idx(input logic [AXI_ADDR_W-1:0] addr);
        logic [AXI_ADDR_W-3:0] word;
        word = addr[AXI_ADDR_W-1:2];
        if (word < REG_N) begin
            return reg_idx_e'(word[3:0]);
        end
        return reg_idx_e'(4'hf);    // unmapped, reads zero
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // write path
    ////////////////////////////////////////////////////////////////////////////

    // aw and w taken together, only one response outstanding
    assign wr_accept = s_axi_awvalid_i && s_axi_wvalid_i && !bvalid_q;

    assign s_axi_awready_o = wr_accept;    // single-cycle pulse
    assign s_axi_wready_o  = wr_accept;

    always_comb begin
        reg_wr_o.valid = wr_accept;
        reg_wr_o.idx   = addr_to_idx(s_axi_awaddr_i);
        reg_wr_o.data  = s_axi_wdata_i;
        reg_wr_o.strb  = s_axi_wstrb_i;
    end

    always_ff @(posedge S_AXI_ACLK) begin
        if (!S_AXI_ARESETN) begin
            bvalid_q <= 1'b0;
        end else if (wr_accept) begin
            bvalid_q <= 1'b1;          // response next cycle
        end else if (s_axi_bready_i) begin
            bvalid_q <= 1'b0;          // held until master takes it
        end
    end

    assign s_axi_bvalid_o = bvalid_q;
    assign s_axi_bresp_o  = RESP_OKAY; // no slave errors generated

    ////////////////////////////////////////////////////////////////////////////
    // read path
    ////////////////////////////////////////////////////////////////////////////

    assign rd_accept       = s_axi_arvalid_i && !rvalid_q;
    assign s_axi_arready_o = rd_accept;

    always_comb begin
        reg_rd_o.valid = rd_accept;
        reg_rd_o.idx   = addr_to_idx(s_axi_araddr_i);
    end

    always_ff @(posedge S_AXI_ACLK) begin
        if (!S_AXI_ARESETN) begin
            rvalid_q <= 1'b0;
        end else if (rd_accept) begin
            rvalid_q <= 1'b1;
        end else if (s_axi_rready_i) begin
            rvalid_q <= 1'b0;
        end
    end

    // map word sampled in the accept cycle, same edge as a possible pop
    always_ff @(posedge S_AXI_ACLK) begin
        if (rd_accept) begin
            rdata_q <= rd_data_i;
        end
    end

    assign s_axi_rvalid_o = rvalid_q;
    assign s_axi_rdata_o  = rdata_q;
    assign s_axi_rresp_o  = RESP_OKAY;

endmodule

`default_nettype wire

/* verilog/uplink_frame_store.sv */
`default_nettype none

module uplink_frame_store
    import uplink_capture_pkg::*;
#(
    parameter int FIFO_DEPTH_LOG2 = 4,    // frame fifo depth
    parameter int ERR_DEPTH_LOG2  = 4     // fec event fifo depth
) (
    input  wire logic                    S_AXI_ACLK,
    input  wire logic                    S_AXI_ARESETN,

    // lpgbt uplink, link clock
    input  wire logic                    clk40_i,
    input  wire frame_t                  uplink_data_i,
    input  wire logic                    uplink_rdy_i,
    input  wire logic                    uplink_fec_i,

    // axi4-lite slave
    input  wire logic [AXI_ADDR_W-1:0]   s_axi_awaddr_i,
    input  wire logic [2:0]              s_axi_awprot_i,
    input  wire logic                    s_axi_awvalid_i,
    output logic                         s_axi_awready_o,
    input  wire logic [AXI_DATA_W-1:0]   s_axi_wdata_i,
    input  wire logic [AXI_DATA_W/8-1:0] s_axi_wstrb_i,
    input  wire logic                    s_axi_wvalid_i,
    output logic                         s_axi_wready_o,
    output logic [1:0]                   s_axi_bresp_o,
    output logic                         s_axi_bvalid_o,
    input  wire logic                    s_axi_bready_i,
    input  wire logic [AXI_ADDR_W-1:0]   s_axi_araddr_i,
    input  wire logic [2:0]              s_axi_arprot_i,
    input  wire logic                    s_axi_arvalid_i,
    output logic                         s_axi_arready_o,
    output logic [AXI_DATA_W-1:0]        s_axi_rdata_o,
    output logic [1:0]                   s_axi_rresp_o,
    output logic                         s_axi_rvalid_o,
    input  wire logic                    s_axi_rready_i
);

    localparam int FRAME_WORDS = REG_FRAME7 - REG_FRAME0 + 1;    // 8 slices
    localparam int PAD_W       = FRAME_WORDS * AXI_DATA_W;

    reg_wr_t               reg_wr;
    reg_rd_t               reg_rd;
    logic [AXI_DATA_W-1:0] rd_data;

    logic       ctrl_en;          // axi domain enable
    logic [1:0] en_sync;          // clk40 copy
    logic       frame_push, frame_pop, frame_empty, frame_full;
    logic [1:0] frame_full_q;     // full seen from the read domain
    frame_t     frame_dout;
    logic [PAD_W-1:0] frame_pad;
    logic       rd9, rd9_q;       // register 9 read strobe, edge detect
    logic       err_pop, err_empty, err_dout;
    logic [AXI_DATA_W-1:0] fec_cnt;
    logic       fec_clr;
    status_t    status;

    axi4lite_reg_slave axi0 (
        .S_AXI_ACLK      (S_AXI_ACLK),
        .S_AXI_ARESETN   (S_AXI_ARESETN),
        .s_axi_awaddr_i  (s_axi_awaddr_i),
        .s_axi_awprot_i  (s_axi_awprot_i),
        .s_axi_awvalid_i (s_axi_awvalid_i),
        .s_axi_awready_o (s_axi_awready_o),
        .s_axi_wdata_i   (s_axi_wdata_i),
        .s_axi_wstrb_i   (s_axi_wstrb_i),
        .s_axi_wvalid_i  (s_axi_wvalid_i),
        .s_axi_wready_o  (s_axi_wready_o),
        .s_axi_bresp_o   (s_axi_bresp_o),
        .s_axi_bvalid_o  (s_axi_bvalid_o),
        .s_axi_bready_i  (s_axi_bready_i),
        .s_axi_araddr_i  (s_axi_araddr_i),
        .s_axi_arprot_i  (s_axi_arprot_i),
        .s_axi_arvalid_i (s_axi_arvalid_i),
        .s_axi_arready_o (s_axi_arready_o),
        .s_axi_rdata_o   (s_axi_rdata_o),
        .s_axi_rresp_o   (s_axi_rresp_o),
        .s_axi_rvalid_o  (s_axi_rvalid_o),
        .s_axi_rready_i  (s_axi_rready_i),
        .reg_wr_o        (reg_wr),
        .reg_rd_o        (reg_rd),
        .rd_data_i       (rd_data)
    );

    ////////////////////////////////////////////////////////////////////////////
    // control, enable crossing, pop edge detect, fec counter
    ////////////////////////////////////////////////////////////////////////////

    assign fec_clr = reg_wr.valid && reg_wr.idx == REG_FEC_CNT && reg_wr.strb[0];
    assign rd9     = reg_rd.valid && reg_rd.idx == REG_FRAME7;
    assign frame_pop = rd9 && !rd9_q && !frame_empty;    // first cycle only
    assign err_pop   = !err_empty;                       // drain every cycle

    always_ff @(posedge S_AXI_ACLK) begin
        if (!S_AXI_ARESETN) begin
            ctrl_en      <= 1'b0;
            rd9_q        <= 1'b0;
            frame_full_q <= '0;
            fec_cnt      <= '0;
        end else begin
            if (reg_wr.valid && reg_wr.idx == REG_CTRL && reg_wr.strb[0]) begin
                ctrl_en <= reg_wr.data[0];
            end
            rd9_q        <= rd9;
            frame_full_q <= {frame_full_q[0], frame_full};
            if (fec_clr) begin
                fec_cnt <= '0;                           // clear beats increment
            end else if (err_pop && err_dout && fec_cnt != '1) begin
                fec_cnt <= fec_cnt + 1'b1;               // saturate at all ones
            end
        end
    end

    // 2-ff enable sync into link domain
    always_ff @(posedge clk40_i) begin
        en_sync <= {en_sync[0], ctrl_en};
    end

    assign frame_push = uplink_rdy_i && en_sync[1];    // fifo drops when full

    ////////////////////////////////////////////////////////////////////////////
    // read mux
    ////////////////////////////////////////////////////////////////////////////

    assign frame_pad    = {{(PAD_W - FRAME_W){1'b0}}, frame_dout};
    assign status.full  = frame_full_q[1];
    assign status.empty = frame_empty;

    always_comb begin
        rd_data = '0;    // unmapped indices
        case (reg_rd.idx)
            REG_CTRL:    rd_data = {{(AXI_DATA_W-1){1'b0}}, ctrl_en};
            REG_STATUS:  rd_data = {{(AXI_DATA_W-2){1'b0}}, status};
            REG_FRAME0, REG_FRAME1, REG_FRAME2, REG_FRAME3,
            REG_FRAME4, REG_FRAME5, REG_FRAME6, REG_FRAME7:
                rd_data = frame_pad[(reg_rd.idx - REG_FRAME0) * AXI_DATA_W +: AXI_DATA_W];
            REG_FEC_CNT: rd_data = fec_cnt;
            default:     rd_data = '0;
        endcase
    end

    cdc_async_fifo #(
        .WIDTH      (FRAME_W),
        .DEPTH_LOG2 (FIFO_DEPTH_LOG2)
    ) frame_fifo (
        .wr_clk_i   (clk40_i),
        .wr_rst_n_i (S_AXI_ARESETN),
        .wr_en_i    (frame_push),
        .din_i      (uplink_data_i),
        .full_o     (frame_full),
        .rd_clk_i   (S_AXI_ACLK),
        .rd_rst_n_i (S_AXI_ARESETN),
        .rd_en_i    (frame_pop),
        .dout_o     (frame_dout),
        .empty_o    (frame_empty)
    );

    cdc_async_fifo #(
        .WIDTH      (1),
        .DEPTH_LOG2 (ERR_DEPTH_LOG2)
    ) err_fifo (
        .wr_clk_i   (clk40_i),
        .wr_rst_n_i (S_AXI_ARESETN),
        .wr_en_i    (uplink_fec_i),    // one event per link cycle
        .din_i      (1'b1),
        .full_o     (),
        .rd_clk_i   (S_AXI_ACLK),
        .rd_rst_n_i (S_AXI_ARESETN),
        .rd_en_i    (err_pop),
        .dout_o     (err_dout),
        .empty_o    (err_empty)
    );

endmodule

`default_nettype wire

/* verif/uplink_frame_store_checker.sv */
`default_nettype none

module uplink_frame_store_checker (
    input wire logic S_AXI_ACLK,
    input wire logic S_AXI_ARESETN,
    input wire logic bvalid_i,
    input wire logic bready_i,
    input wire logic rvalid_i,
    input wire logic rready_i,
    input wire logic pop_i,      // frame fifo pop
    input wire logic empty_i     // frame fifo empty, read side
);

    timeunit 1ns;
    timeprecision 100ps;

    // responses held until taken
    assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
        bvalid_i && !bready_i |=> bvalid_i)
        else $error("bvalid dropped before bready");

    assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
        rvalid_i && !rready_i |=> rvalid_i)
        else $error("rvalid dropped before rready");

    assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
        pop_i |-> !empty_i)
        else $error("frame fifo popped while empty");

    // edge detect gives one pop per register 9 read
    assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
        pop_i |=> !pop_i)
        else $error("frame fifo popped on two consecutive cycles");

endmodule

bind uplink_frame_store uplink_frame_store_checker uplink_checks (
    .S_AXI_ACLK    (S_AXI_ACLK),
    .S_AXI_ARESETN (S_AXI_ARESETN),
    .bvalid_i      (s_axi_bvalid_o),
    .bready_i      (s_axi_bready_i),
    .rvalid_i      (s_axi_rvalid_o),
    .rready_i      (s_axi_rready_i),
    .pop_i         (frame_pop),
    .empty_i       (frame_empty)
);

`default_nettype wire

/* verif/uplink_frame_store_tb.sv */
`default_nettype none

module uplink_frame_store_tb
    import uplink_capture_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int FIFO_DEPTH_LOG2 = 4;
    localparam int ERR_DEPTH_LOG2  = 4;
    localparam int DEPTH       = 1 << FIFO_DEPTH_LOG2;
    localparam int FRAME_WORDS = (FRAME_W + AXI_DATA_W - 1) / AXI_DATA_W;
    localparam int N_IDLE      = 4;            // frames sent with capture off
    localparam int N_ORDER     = 3;            // in-order readback
    localparam int N_OVER      = DEPTH + 5;    // overfill, last 5 dropped
    localparam int N_FEC       = 5;            // below err fifo depth
    localparam int SETTLE_CYC  = 12;           // covers the 2..4 cycle crossings
    localparam int POLL_MAX    = 20;
    localparam int STALL_CYC   = 3;            // cycles of response back-pressure
    localparam int READY_SAMPLE_NS = 10;       // mid low phase of S_AXI_ACLK
    localparam int TXN_MAX     = (N_ORDER + DEPTH) * FRAME_WORDS + POLL_MAX + 40;
    localparam int WATCHDOG_NS = 2 * ((TXN_MAX * 4 + 8 * SETTLE_CYC + 16) * 40
                                 + (2 * (N_IDLE + N_ORDER + N_OVER) + N_FEC + 8) * 25);

    // dut ports, names match for the .* hookup
    logic S_AXI_ACLK, S_AXI_ARESETN, clk40_i;
    frame_t uplink_data_i;
    logic uplink_rdy_i, uplink_fec_i;
    logic [AXI_ADDR_W-1:0] s_axi_awaddr_i, s_axi_araddr_i;
    logic [2:0] s_axi_awprot_i, s_axi_arprot_i;
    logic s_axi_awvalid_i, s_axi_awready_o, s_axi_wvalid_i, s_axi_wready_o;
    logic [AXI_DATA_W-1:0] s_axi_wdata_i, s_axi_rdata_o;
    logic [AXI_DATA_W/8-1:0] s_axi_wstrb_i;
    logic [1:0] s_axi_bresp_o, s_axi_rresp_o;
    logic s_axi_bvalid_o, s_axi_bready_i;
    logic s_axi_arvalid_i, s_axi_arready_o, s_axi_rvalid_o, s_axi_rready_i;

    // reference model state
    logic model_en;
    frame_t model_q[$];                        // frames the fifo should hold
    logic [AXI_DATA_W-1:0] model_fec;
    logic [31:0] lfsr;

    // expected read responses, in issue order
    string exp_name_q[$];
    logic [AXI_DATA_W-1:0] exp_word_q[$];
    int exp_kind_q[$];                         // 0 resp only, 1 word, 2 status

    logic [AXI_DATA_W-1:0] rd;

    uplink_frame_store #(
        .FIFO_DEPTH_LOG2 (FIFO_DEPTH_LOG2),
        .ERR_DEPTH_LOG2  (ERR_DEPTH_LOG2)
    ) UUT (.*);

    initial begin
        S_AXI_ACLK = 1'b0;
        forever #20 S_AXI_ACLK = ~S_AXI_ACLK;
    end

    initial begin
        clk40_i = 1'b0;
        forever #12.5 clk40_i = ~clk40_i;    // 40 MHz link
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("TESTS FAILED");
        $fatal(1, "run stopped");
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // stimulus source and reference model
    ////////////////////////////////////////////////////////////////////////////

    // galois form, x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic next_frame(output frame_t f);
        for (int b = 0; b < FRAME_W; b++) begin
            lfsr = lfsr_next(lfsr);          // one step per bit
            f[b] = lfsr[0];
        end
    endtask

    function automatic logic [AXI_DATA_W-1:0] ref_word(input int idx);
        logic [AXI_DATA_W-1:0] w;
        frame_t head;
        int base;
        w = '0;
        head = (model_q.size() > 0) ? model_q[0] : '0;
        if (idx == REG_CTRL) begin
            w[0] = model_en;
        end else if (idx == REG_STATUS) begin
            w[0] = (model_q.size() == 0);
            w[1] = (model_q.size() == DEPTH);
        end else if (idx >= REG_FRAME0 && idx <= REG_FRAME7) begin
            base = (idx - REG_FRAME0) * AXI_DATA_W;
            for (int b = 0; b < AXI_DATA_W; b++) begin
                if (base + b < FRAME_W) begin
                    w[b] = head[base + b];   // top slice zero-extended
                end
            end
        end else if (idx == REG_FEC_CNT) begin
            w = model_fec;
        end
        return w;                            // unmapped reads zero
    endfunction

    task automatic check_word(input string name, input logic [AXI_DATA_W-1:0] exp_w, act_w);
        if (act_w !== exp_w) begin
            abort_run($sformatf("error %s expected %h actual %h", name, exp_w, act_w));
        end
    endtask

    task automatic check_status(input string name, input status_t exp_s, act_s);
        if (act_s !== exp_s) begin
            abort_run($sformatf("error %s expected full=%b empty=%b actual full=%b empty=%b",
                                name, exp_s.full, exp_s.empty, act_s.full, act_s.empty));
        end
    endtask

    task automatic check_frame(input string name, input frame_t exp_f, act_f);
        if (act_f !== exp_f) begin
            abort_run($sformatf("error %s expected %h actual %h", name, exp_f, act_f));
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // bus and link drivers, all on falling edges
    ////////////////////////////////////////////////////////////////////////////

    task automatic axi_write(input int idx, input logic [31:0] data, input logic [3:0] strb);
        @(negedge S_AXI_ACLK);
        s_axi_awaddr_i  = AXI_ADDR_W'(idx * 4);
        s_axi_wdata_i   = data;
        s_axi_wstrb_i   = strb;
        s_axi_awvalid_i = 1'b1;
        s_axi_wvalid_i  = 1'b1;
        #(READY_SAMPLE_NS);                  // readies settled, before the accept edge
        check_word("write awready", 32'h1, AXI_DATA_W'(s_axi_awready_o));
        check_word("write wready", 32'h1, AXI_DATA_W'(s_axi_wready_o));
        @(negedge S_AXI_ACLK);
        check_word("write awready pulse", '0, AXI_DATA_W'(s_axi_awready_o));
        check_word("write wready pulse", '0, AXI_DATA_W'(s_axi_wready_o));
        while (!s_axi_bvalid_o) begin
            @(negedge S_AXI_ACLK);
        end
        s_axi_awvalid_i = 1'b0;
        s_axi_wvalid_i  = 1'b0;
        check_word("write bresp", '0, AXI_DATA_W'(s_axi_bresp_o));
        if (idx == REG_CTRL && strb[0]) begin
            model_en = data[0];
        end
        if (idx == REG_FEC_CNT && strb[0]) begin
            model_fec = '0;
        end
    endtask

    task automatic axi_read(input int idx, input string name, input int kind,
                            output logic [AXI_DATA_W-1:0] data);
        @(negedge S_AXI_ACLK);
        exp_name_q.push_back(name);
        exp_word_q.push_back(ref_word(idx));
        exp_kind_q.push_back(kind);
        s_axi_araddr_i  = AXI_ADDR_W'(idx * 4);
        s_axi_arvalid_i = 1'b1;
        #(READY_SAMPLE_NS);
        check_word({name, " arready"}, 32'h1, AXI_DATA_W'(s_axi_arready_o));
        @(negedge S_AXI_ACLK);
        check_word({name, " arready pulse"}, '0, AXI_DATA_W'(s_axi_arready_o));
        while (!s_axi_rvalid_o) begin
            @(negedge S_AXI_ACLK);
        end
        s_axi_arvalid_i = 1'b0;
        data = s_axi_rdata_o;
        if (idx == REG_FRAME7 && model_q.size() > 0) begin
            void'(model_q.pop_front());      // top slice read pops the head
        end
    endtask

    task automatic read_frame(input string name);
        frame_t exp_f, act_f;
        logic [AXI_DATA_W-1:0] w;
        if (model_q.size() == 0) begin
            abort_run("frame readback attempted with no frame expected");
        end
        exp_f = model_q[0];
        act_f = '0;
        for (int k = 0; k < FRAME_WORDS; k++) begin
            axi_read(REG_FRAME0 + k, name, 1, w);
            for (int b = 0; b < AXI_DATA_W; b++) begin
                if (k * AXI_DATA_W + b < FRAME_W) begin
                    act_f[k * AXI_DATA_W + b] = w[b];
                end
            end
        end
        check_frame(name, exp_f, act_f);
    endtask

    task automatic send_frame();
        frame_t f;
        next_frame(f);
        @(negedge clk40_i);
        uplink_data_i = f;
        uplink_rdy_i  = 1'b1;
        @(negedge clk40_i);
        uplink_rdy_i  = 1'b0;
        if (model_en && model_q.size() < DEPTH) begin
            model_q.push_back(f);            // dropped when full or disabled
        end
    endtask

    task automatic send_fec(input int n);
        @(negedge clk40_i);
        uplink_fec_i = 1'b1;
        repeat (n) @(negedge clk40_i);       // n link edges see the pulse
        uplink_fec_i = 1'b0;
        for (int i = 0; i < n; i++) begin
            if (model_fec != '1) begin
                model_fec = model_fec + 1'b1;
            end
        end
    endtask

    task automatic wait_crossing();
        repeat (SETTLE_CYC) @(negedge S_AXI_ACLK);
    endtask

    task automatic poll_fec_count();
        logic [AXI_DATA_W-1:0] prev, cur;
        int same;
        same = 0;
        axi_read(REG_FEC_CNT, "fec poll", 0, prev);
        for (int i = 0; i < POLL_MAX && same < 2; i++) begin
            axi_read(REG_FEC_CNT, "fec poll", 0, cur);
            same = (cur == prev) ? same + 1 : 0;
            prev = cur;
        end
        if (same < 2) begin
            abort_run("fec count was still changing when the poll limit ran out");
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // response compare and watchdog
    ////////////////////////////////////////////////////////////////////////////

    initial begin : compare_responses
        string name;
        logic [AXI_DATA_W-1:0] exp_w;
        int kind;
        logic resp_seen;                     // current rvalid already checked
        resp_seen = 1'b0;
        forever begin
            @(negedge S_AXI_ACLK);
            if (!s_axi_rvalid_o) begin
                resp_seen = 1'b0;
            end else if (!resp_seen) begin
                resp_seen = 1'b1;            // each response once, stalled or not
                if (exp_word_q.size() == 0) begin
                    abort_run("read response arrived with no read outstanding");
                end else begin
                    name  = exp_name_q.pop_front();
                    exp_w = exp_word_q.pop_front();
                    kind  = exp_kind_q.pop_front();
                    check_word({name, " rresp"}, '0, AXI_DATA_W'(s_axi_rresp_o));
                    if (kind == 2) begin
                        check_status(name, status_t'(exp_w[1:0]),
                                     status_t'(s_axi_rdata_o[1:0]));
                    end
                    if (kind != 0) begin
                        check_word(name, exp_w, s_axi_rdata_o);
                    end
                end
            end
        end
    end

    initial begin : watchdog
        #(WATCHDOG_NS);
        abort_run($sformatf("timeout after %0d ns, a bus transfer never completed",
                            WATCHDOG_NS));
    end

    ////////////////////////////////////////////////////////////////////////////
    // test sequence
    ////////////////////////////////////////////////////////////////////////////

    initial begin : run_tests
        S_AXI_ARESETN   = 1'b0;
        uplink_data_i   = '0;
        uplink_rdy_i    = 1'b0;
        uplink_fec_i    = 1'b0;
        s_axi_awaddr_i  = '0;
        s_axi_awprot_i  = '0;
        s_axi_awvalid_i = 1'b0;
        s_axi_wdata_i   = '0;
        s_axi_wstrb_i   = '0;
        s_axi_wvalid_i  = 1'b0;
        s_axi_bready_i  = 1'b1;              // no back-pressure
        s_axi_araddr_i  = '0;
        s_axi_arprot_i  = '0;
        s_axi_arvalid_i = 1'b0;
        s_axi_rready_i  = 1'b1;
        model_en  = 1'b0;
        model_fec = '0;
        lfsr      = 32'h353c;
        repeat (8) @(negedge S_AXI_ACLK);
        S_AXI_ARESETN = 1'b1;
        wait_crossing();                     // fifo side resets release

        axi_read(REG_CTRL, "reset ctrl", 1, rd);
        axi_read(REG_STATUS, "reset status", 2, rd);
        axi_read(REG_FEC_CNT, "reset fec count", 1, rd);

        // capture off, nothing may land
        for (int i = 0; i < N_IDLE; i++) begin
            send_frame();
        end
        wait_crossing();
        axi_read(REG_STATUS, "status capture off", 2, rd);
        axi_write(REG_CTRL, 32'h1, 4'hf);
        axi_read(REG_CTRL, "ctrl readback", 1, rd);
        repeat (5) @(negedge clk40_i);       // enable sync, 2..3 link cycles

        for (int i = 0; i < N_ORDER; i++) begin
            send_frame();
        end
        wait_crossing();
        axi_read(REG_STATUS, "status after capture", 2, rd);
        repeat (2) begin
            for (int k = REG_FRAME0; k < REG_FRAME7; k++) begin
                axi_read(k, "frame word repeat", 1, rd);    // must not pop
            end
        end
        for (int i = 0; i < N_ORDER; i++) begin
            read_frame("in-order frame");
        end
        wait_crossing();
        axi_read(REG_STATUS, "status in-order drained", 2, rd);

        // overfill, only DEPTH frames kept
        for (int i = 0; i < N_OVER; i++) begin
            send_frame();
        end
        wait_crossing();
        axi_read(REG_STATUS, "status overfill", 2, rd);
        for (int i = 0; i < DEPTH; i++) begin
            read_frame("overfill frame");
        end
        wait_crossing();
        axi_read(REG_STATUS, "status overfill drained", 2, rd);

        send_fec(N_FEC);
        poll_fec_count();
        axi_read(REG_FEC_CNT, "fec count", 1, rd);
        axi_write(REG_FEC_CNT, 32'h0, 4'b1110);             // no clear
        axi_read(REG_FEC_CNT, "fec count kept", 1, rd);
        axi_write(REG_FEC_CNT, 32'h0, 4'b0001);
        axi_read(REG_FEC_CNT, "fec count cleared", 1, rd);

        // held responses, next transfer of each kind must wait
        @(negedge S_AXI_ACLK);
        s_axi_bready_i = 1'b0;
        s_axi_rready_i = 1'b0;
        axi_write(REG_CTRL, 32'h1, 4'h1);
        axi_read(REG_CTRL, "ctrl under back-pressure", 1, rd);
        @(negedge S_AXI_ACLK);
        s_axi_awvalid_i = 1'b1;              // second write and read offered
        s_axi_wvalid_i  = 1'b1;
        s_axi_arvalid_i = 1'b1;
        repeat (STALL_CYC) begin
            #(READY_SAMPLE_NS);
            check_word("awready while bvalid held", '0, AXI_DATA_W'(s_axi_awready_o));
            check_word("wready while bvalid held", '0, AXI_DATA_W'(s_axi_wready_o));
            check_word("arready while rvalid held", '0, AXI_DATA_W'(s_axi_arready_o));
            @(negedge S_AXI_ACLK);
        end
        s_axi_awvalid_i = 1'b0;
        s_axi_wvalid_i  = 1'b0;
        s_axi_arvalid_i = 1'b0;
        s_axi_bready_i  = 1'b1;
        s_axi_rready_i  = 1'b1;

        axi_read(11, "unmapped word 11", 1, rd);
        axi_read(300, "unmapped word 300", 1, rd);
        repeat (2) @(negedge S_AXI_ACLK);

        if (exp_word_q.size() != 0) begin
            abort_run($sformatf("%0d read responses never arrived", exp_word_q.size()));
        end else begin
            $display("TESTS PASSED");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* files.f */
verilog/uplink_capture_pkg.sv
verilog/cdc_async_fifo.sv
verilog/axi4lite_reg_slave.sv
verilog/uplink_frame_store.sv
verif/uplink_frame_store_checker.sv
verif/uplink_frame_store_tb.sv

/* run_sim.sh */
#!/bin/sh
# builds the uplink frame store testbench with verilator, runs it, scans the log

cd "$(dirname "$0")" || exit 1

TOP=uplink_frame_store_tb
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module "$TOP" -f files.f -o "$TOP"
build_status=$?
if [ $build_status -ne 0 ]; then
    echo "verilator build failed with status $build_status"
    exit 1
fi

./obj_dir/"$TOP" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"

if grep -q "TESTS FAILED" "$LOG"; then
    echo "simulation reported a failure, see $LOG"
    exit 1
fi
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi
exit 0
